// File: design/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// byte address as seen by both requesters
`define MEM_ADDR_W 17

// ram holds 2**12 bytes, upper address bits are ignored
`define MEM_DEPTH_LOG2 12

// instruction and data word
`define MEM_WORD_W 32

`endif

// File: design/memReqPkg.sv
`default_nettype none

package memReqPkg;

    // direction of a data port access
    typedef enum logic {
        OpLoad  = 1'b0,
        OpStore = 1'b1
    } memOp;

    // bytes moved by one access
    typedef enum logic [2:0] {
        LenByte = 3'd1,
        LenHalf = 3'd2,
        LenWord = 3'd4
    } accessLen;

endpackage

`default_nettype wire

// File: design/ramBusPkg.sv
`default_nettype none

package ramBusPkg;

    // shared by both sequencers
    typedef enum logic [1:0] {
        SeqIdle    = 2'd0,
        SeqIssue   = 2'd1,
        SeqDrain   = 2'd2,
        SeqRespond = 2'd3
    } seqState;

    // who holds the ram port
    typedef enum logic [1:0] {
        OwnerNone  = 2'd0,
        OwnerFetch = 2'd1,
        OwnerData  = 2'd2
    } busOwner;

endpackage

`default_nettype wire

// File: design/byteBusIf.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

interface byteBusIf;
    logic                   req;
    logic [`MEM_ADDR_W-1:0] addr;
    logic                   we;
    logic [7:0]             wdata;
    logic                   last;
    logic                   gnt;
    // byte arrives one cycle after its granted cycle
    logic [7:0]             rdata;

    modport seq (
        output req, addr, we, wdata, last,
        input  gnt, rdata
    );

    modport arb (
        input  req, addr, we, wdata, last,
        output gnt, rdata
    );
endinterface

`default_nettype wire

// File: design/fetchSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module fetchSequencer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    reqValid,
    output logic                   reqReady,
    input  wire [`MEM_ADDR_W-1:0]  addr,
    output logic                   respValid,
    input  wire                    respReady,
    output logic [`MEM_WORD_W-1:0] inst,
    byteBusIf.seq                  bus
);
    ramBusPkg::seqState     state;
    logic [`MEM_ADDR_W-1:0] baseAddr;
    logic [1:0]             issueCnt;
    logic [1:0]             rxCnt;
    logic                   rdPending;
    logic [`MEM_WORD_W-1:0] word;

    assign reqReady  = (state == ramBusPkg::SeqIdle);
    assign respValid = (state == ramBusPkg::SeqRespond);
    assign inst      = word;

    // always four reads at ascending addresses
    assign bus.req   = (state == ramBusPkg::SeqIssue);
    assign bus.addr  = baseAddr + `MEM_ADDR_W'(issueCnt);
    assign bus.we    = 1'b0;
    assign bus.wdata = 8'h00;
    assign bus.last  = (issueCnt == 2'd3);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ramBusPkg::SeqIdle;
            issueCnt  <= 2'd0;
            rxCnt     <= 2'd0;
            rdPending <= 1'b0;
        end else begin
            rdPending <= bus.req && bus.gnt;
            if (rdPending) begin
                rxCnt <= rxCnt + 2'd1;
            end
            case (state)
                ramBusPkg::SeqIdle: begin
                    if (reqValid) begin
                        state    <= ramBusPkg::SeqIssue;
                        issueCnt <= 2'd0;
                        rxCnt    <= 2'd0;
                    end
                end
                ramBusPkg::SeqIssue: begin
                    if (bus.gnt) begin
                        issueCnt <= issueCnt + 2'd1;
                        if (bus.last) begin
                            state <= ramBusPkg::SeqDrain;
                        end
                    end
                end
                // fourth byte lands during this cycle
                ramBusPkg::SeqDrain: state <= ramBusPkg::SeqRespond;
                default: begin
                    if (respReady) begin
                        state <= ramBusPkg::SeqIdle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            baseAddr <= addr;
        end
        // lane chosen by bytes already returned
        if (rdPending) begin
            word[8*rxCnt +: 8] <= bus.rdata;
        end
    end

    assertAddrHeld: assert property (
        @(posedge clk) disable iff (rst)
        bus.req && !bus.gnt |=> bus.req && $stable(bus.addr)
    );
endmodule

`default_nettype wire

// File: design/dataSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module dataSequencer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    reqValid,
    output logic                   reqReady,
    input  wire memReqPkg::memOp   op,
    input  wire memReqPkg::accessLen len,
    input  wire [`MEM_ADDR_W-1:0]  addr,
    input  wire [`MEM_WORD_W-1:0]  wdata,
    output logic                   respValid,
    input  wire                    respReady,
    output logic [`MEM_WORD_W-1:0] rdata,
    byteBusIf.seq                  bus
);
    ramBusPkg::seqState     state;
    memReqPkg::memOp        opReg;
    memReqPkg::accessLen    lenReg;
    logic [`MEM_ADDR_W-1:0] baseAddr;
    logic [`MEM_WORD_W-1:0] storeData;
    logic [2:0]             issueCnt;
    logic [1:0]             rxCnt;
    logic                   rdPending;
    logic [`MEM_WORD_W-1:0] word;

    assign reqReady  = (state == ramBusPkg::SeqIdle);
    assign respValid = (state == ramBusPkg::SeqRespond);
    // stores leave the cleared word in place
    assign rdata     = word;

    assign bus.req   = (state == ramBusPkg::SeqIssue);
    assign bus.addr  = baseAddr + `MEM_ADDR_W'(issueCnt);
    assign bus.we    = (opReg == memReqPkg::OpStore);
    assign bus.wdata = storeData[8*issueCnt[1:0] +: 8];
    assign bus.last  = (issueCnt + 3'd1 == 3'(lenReg));

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ramBusPkg::SeqIdle;
            issueCnt  <= 3'd0;
            rxCnt     <= 2'd0;
            rdPending <= 1'b0;
        end else begin
            rdPending <= bus.req && bus.gnt && !bus.we;
            if (rdPending) begin
                rxCnt <= rxCnt + 2'd1;
            end
            case (state)
                ramBusPkg::SeqIdle: begin
                    if (reqValid) begin
                        state    <= ramBusPkg::SeqIssue;
                        issueCnt <= 3'd0;
                        rxCnt    <= 2'd0;
                    end
                end
                ramBusPkg::SeqIssue: begin
                    if (bus.gnt) begin
                        issueCnt <= issueCnt + 3'd1;
                        if (bus.last) begin
                            state <= ramBusPkg::SeqDrain;
                        end
                    end
                end
                // a store idles here too so both ops take len+2
                ramBusPkg::SeqDrain: state <= ramBusPkg::SeqRespond;
                default: begin
                    if (respReady) begin
                        state <= ramBusPkg::SeqIdle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            opReg     <= op;
            lenReg    <= len;
            baseAddr  <= addr;
            storeData <= wdata;
            // zero extension comes from this clear
            word      <= '0;
        end else if (rdPending) begin
            word[8*rxCnt +: 8] <= bus.rdata;
        end
    end

    // no byte is issued past len
    assertLastOnLen: assert property (
        @(posedge clk) disable iff (rst)
        bus.req |-> issueCnt < 3'(lenReg)
    );
endmodule

`default_nettype wire

// File: design/ramArbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module ramArbiter (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   ioBufferFull,
    byteBusIf.arb                 fetchBus,
    byteBusIf.arb                 dataBus,
    output logic                  ramWe,
    output logic [`MEM_ADDR_W-1:0] ramAddr,
    output logic [7:0]            ramWdata,
    input  wire [7:0]             ramRdata
);
    ramBusPkg::busOwner owner;
    ramBusPkg::busOwner grantee;
    ramBusPkg::busOwner rdOwner;
    logic               granted;
    logic               selWe;
    logic               selLast;

    // current owner keeps the port, data wins when it is free
    always_comb begin
        grantee = ramBusPkg::OwnerNone;
        if (!ioBufferFull) begin
            case (owner)
                ramBusPkg::OwnerFetch: begin
                    if (fetchBus.req) begin
                        grantee = ramBusPkg::OwnerFetch;
                    end
                end
                ramBusPkg::OwnerData: begin
                    if (dataBus.req) begin
                        grantee = ramBusPkg::OwnerData;
                    end
                end
                default: begin
                    if (dataBus.req) begin
                        grantee = ramBusPkg::OwnerData;
                    end else if (fetchBus.req) begin
                        grantee = ramBusPkg::OwnerFetch;
                    end
                end
            endcase
        end
    end

    assign fetchBus.gnt = (grantee == ramBusPkg::OwnerFetch);
    assign dataBus.gnt  = (grantee == ramBusPkg::OwnerData);
    assign granted      = (grantee != ramBusPkg::OwnerNone);

    assign ramAddr  = fetchBus.gnt ? fetchBus.addr  : dataBus.addr;
    assign ramWdata = fetchBus.gnt ? fetchBus.wdata : dataBus.wdata;
    assign selWe    = fetchBus.gnt ? fetchBus.we    : dataBus.we;
    assign selLast  = fetchBus.gnt ? fetchBus.last  : dataBus.last;
    assign ramWe    = granted && selWe;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner   <= ramBusPkg::OwnerNone;
            rdOwner <= ramBusPkg::OwnerNone;
        end else begin
            if (granted) begin
                owner <= selLast ? ramBusPkg::OwnerNone : grantee;
            end
            rdOwner <= (granted && !selWe) ? grantee : ramBusPkg::OwnerNone;
        end
    end

    // read byte goes back to whoever issued it a cycle ago
    assign fetchBus.rdata = (rdOwner == ramBusPkg::OwnerFetch) ? ramRdata : 8'h00;
    assign dataBus.rdata  = (rdOwner == ramBusPkg::OwnerData)  ? ramRdata : 8'h00;

    assertOneGrant: assert property (
        @(posedge clk) disable iff (rst)
        !(fetchBus.gnt && dataBus.gnt)
    );

    assertStallBlocks: assert property (
        @(posedge clk) disable iff (rst)
        ioBufferFull |-> !fetchBus.gnt && !dataBus.gnt && !ramWe
    );
endmodule

`default_nettype wire

// File: design/byteRam.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module byteRam (
    input  wire                   clk,
    input  wire                   we,
    input  wire [`MEM_ADDR_W-1:0] addr,
    input  wire [7:0]             wdata,
    output logic [7:0]            rdata
);
    logic [7:0] mem [0:(2**`MEM_DEPTH_LOG2)-1];
    logic [`MEM_DEPTH_LOG2-1:0] index;

    // upper address bits wrap onto the array
    assign index = addr[`MEM_DEPTH_LOG2-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
        // read returns the old byte on a write cycle
        rdata <= mem[index];
    end
endmodule

`default_nettype wire

// File: design/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module memSubsystem (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      ioBufferFull,
    input  wire                      fetchReqValid,
    output logic                     fetchReqReady,
    input  wire [`MEM_ADDR_W-1:0]    fetchAddr,
    output logic                     instValid,
    input  wire                      instReady,
    output logic [`MEM_WORD_W-1:0]   inst,
    input  wire                      dataReqValid,
    output logic                     dataReqReady,
    input  wire memReqPkg::memOp     dataOp,
    input  wire memReqPkg::accessLen dataLen,
    input  wire [`MEM_ADDR_W-1:0]    dataAddr,
    input  wire [`MEM_WORD_W-1:0]    dataWdata,
    output logic                     dataRespValid,
    input  wire                      dataRespReady,
    output logic [`MEM_WORD_W-1:0]   dataRdata
);
    logic                   ramWe;
    logic [`MEM_ADDR_W-1:0] ramAddr;
    logic [7:0]             ramWdata;
    logic [7:0]             ramRdata;

    byteBusIf fetchBus ();
    byteBusIf dataBus ();

    fetchSequencer fetchSeq_i (
        .clk(clk), .rst(rst),
        .reqValid(fetchReqValid), .reqReady(fetchReqReady), .addr(fetchAddr),
        .respValid(instValid), .respReady(instReady), .inst(inst),
        .bus(fetchBus)
    );

    dataSequencer dataSeq_i (
        .clk(clk), .rst(rst),
        .reqValid(dataReqValid), .reqReady(dataReqReady),
        .op(dataOp), .len(dataLen), .addr(dataAddr), .wdata(dataWdata),
        .respValid(dataRespValid), .respReady(dataRespReady), .rdata(dataRdata),
        .bus(dataBus)
    );

    ramArbiter arbiter_i (
        .clk(clk), .rst(rst), .ioBufferFull(ioBufferFull),
        .fetchBus(fetchBus), .dataBus(dataBus),
        .ramWe(ramWe), .ramAddr(ramAddr), .ramWdata(ramWdata), .ramRdata(ramRdata)
    );

    byteRam ram_i (
        .clk(clk), .we(ramWe), .addr(ramAddr), .wdata(ramWdata), .rdata(ramRdata)
    );
endmodule

`default_nettype wire

// File: test/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_macros.svh"

module memSubsystemTb;
    localparam int PortFetch = 0;
    localparam int PortData  = 1;
    localparam int PortBoth  = 2;

    typedef struct {
        int                     port;
        memReqPkg::memOp        op;
        memReqPkg::accessLen    len;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_WORD_W-1:0] wdata;
        bit                     stall;
        bit                     bp;
    } stimEntry;

    logic                   clk;
    logic                   rst;
    logic                   ioBufferFull;
    logic                   fetchReqValid;
    logic                   fetchReqReady;
    logic [`MEM_ADDR_W-1:0] fetchAddr;
    logic                   instValid;
    logic                   instReady;
    logic [`MEM_WORD_W-1:0] inst;
    logic                   dataReqValid;
    logic                   dataReqReady;
    memReqPkg::memOp        dataOp;
    memReqPkg::accessLen    dataLen;
    logic [`MEM_ADDR_W-1:0] dataAddr;
    logic [`MEM_WORD_W-1:0] dataWdata;
    logic                   dataRespValid;
    logic                   dataRespReady;
    logic [`MEM_WORD_W-1:0] dataRdata;

    stimEntry   entries[$];
    logic [7:0] shadow [0:(2**`MEM_DEPTH_LOG2)-1];
    int         errorCount = 0;
    bit         tableLoaded = 1'b0;

    memSubsystem memSubsystem_i (
        .clk(clk), .rst(rst), .ioBufferFull(ioBufferFull),
        .fetchReqValid(fetchReqValid), .fetchReqReady(fetchReqReady), .fetchAddr(fetchAddr),
        .instValid(instValid), .instReady(instReady), .inst(inst),
        .dataReqValid(dataReqValid), .dataReqReady(dataReqReady), .dataOp(dataOp),
        .dataLen(dataLen), .dataAddr(dataAddr), .dataWdata(dataWdata),
        .dataRespValid(dataRespValid), .dataRespReady(dataRespReady), .dataRdata(dataRdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic failRun(input string msg);
        errorCount++;
        $display("ERROR @%0t: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic checkInst(input logic [`MEM_WORD_W-1:0] got, input logic [`MEM_WORD_W-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("inst %h, expected %h", got, exp));
        end
    endtask

    task automatic checkData(input logic [`MEM_WORD_W-1:0] got, input logic [`MEM_WORD_W-1:0] exp,
                             input memReqPkg::memOp op);
        if (got !== exp) begin
            failRun($sformatf("%s rdata %h, expected %h", op.name(), got, exp));
        end
    endtask

    // little-endian, zero-extended past len
    function automatic logic [`MEM_WORD_W-1:0] readShadow(input logic [`MEM_ADDR_W-1:0] addr,
                                                          input int len);
        logic [`MEM_WORD_W-1:0] word;
        logic [`MEM_ADDR_W-1:0] a;
        word = '0;
        for (int k = 0; k < len; k++) begin
            a = addr + `MEM_ADDR_W'(k);
            word[8*k +: 8] = shadow[a[`MEM_DEPTH_LOG2-1:0]];
        end
        return word;
    endfunction

    task automatic writeShadow(input logic [`MEM_ADDR_W-1:0] addr,
                               input logic [`MEM_WORD_W-1:0] wdata, input int len);
        logic [`MEM_ADDR_W-1:0] a;
        for (int k = 0; k < len; k++) begin
            a = addr + `MEM_ADDR_W'(k);
            shadow[a[`MEM_DEPTH_LOG2-1:0]] = wdata[8*k +: 8];
        end
    endtask

    task automatic addEntry(input int port, input memReqPkg::memOp op,
                            input memReqPkg::accessLen len, input logic [`MEM_ADDR_W-1:0] addr,
                            input logic [`MEM_WORD_W-1:0] wdata, input bit stall, input bit bp);
        stimEntry e;
        e = '{port, op, len, addr, wdata, stall, bp};
        entries.push_back(e);
    endtask

    task automatic loadTable();
        addEntry(PortData,  memReqPkg::OpStore, memReqPkg::LenWord, 17'h00100, 32'h11223344, 0, 0);
        addEntry(PortData,  memReqPkg::OpStore, memReqPkg::LenWord, 17'h00104, 32'hA5B6C7D8, 0, 0);
        addEntry(PortData,  memReqPkg::OpLoad,  memReqPkg::LenWord, 17'h00100, 32'h0, 0, 0);
        addEntry(PortData,  memReqPkg::OpLoad,  memReqPkg::LenWord, 17'h00104, 32'h0, 0, 0);
        // narrow stores must leave the other lanes alone
        addEntry(PortData,  memReqPkg::OpStore, memReqPkg::LenByte, 17'h00101, 32'hFFFFFFEE, 0, 0);
        addEntry(PortData,  memReqPkg::OpStore, memReqPkg::LenHalf, 17'h00106, 32'h55559876, 0, 0);
        addEntry(PortData,  memReqPkg::OpLoad,  memReqPkg::LenByte, 17'h00101, 32'h0, 0, 0);
        addEntry(PortData,  memReqPkg::OpLoad,  memReqPkg::LenHalf, 17'h00102, 32'h0, 0, 0);
        addEntry(PortData,  memReqPkg::OpLoad,  memReqPkg::LenWord, 17'h00100, 32'h0, 0, 0);
        addEntry(PortData,  memReqPkg::OpLoad,  memReqPkg::LenHalf, 17'h00106, 32'h0, 0, 0);
        addEntry(PortFetch, memReqPkg::OpLoad,  memReqPkg::LenWord, 17'h00100, 32'h0, 0, 0);
        addEntry(PortFetch, memReqPkg::OpLoad,  memReqPkg::LenWord, 17'h00104, 32'h0, 0, 0);
        // data wins the first burst, so the fetch sees the new word
        addEntry(PortBoth,  memReqPkg::OpStore, memReqPkg::LenWord, 17'h00108, 32'hCAFEF00D, 0, 0);
        addEntry(PortBoth,  memReqPkg::OpLoad,  memReqPkg::LenWord, 17'h00104, 32'h0, 0, 0);
        addEntry(PortData,  memReqPkg::OpStore, memReqPkg::LenWord, 17'h0010C, 32'h0BADBEEF, 1, 0);
        addEntry(PortBoth,  memReqPkg::OpLoad,  memReqPkg::LenWord, 17'h0010C, 32'h0, 1, 0);
        addEntry(PortFetch, memReqPkg::OpLoad,  memReqPkg::LenWord, 17'h00104, 32'h0, 0, 1);
        addEntry(PortData,  memReqPkg::OpLoad,  memReqPkg::LenByte, 17'h0010F, 32'h0, 0, 1);
        addEntry(PortBoth,  memReqPkg::OpLoad,  memReqPkg::LenWord, 17'h00108, 32'h0, 1, 1);
        // upper address bits alias onto the same ram byte
        addEntry(PortData,  memReqPkg::OpStore, memReqPkg::LenWord, 17'h10200, 32'h600DF00D, 0, 0);
        addEntry(PortBoth,  memReqPkg::OpLoad,  memReqPkg::LenWord, 17'h00200, 32'h0, 0, 1);
    endtask

    task automatic runEntry(input stimEntry e);
        logic [`MEM_WORD_W-1:0] expInst;
        logic [`MEM_WORD_W-1:0] expData;
        bit                     doneF;
        bit                     doneD;
        int                     stallLeft;
        expInst = '0;
        expData = '0;
        doneF = (e.port == PortData);
        doneD = (e.port == PortFetch);
        if (!doneD) begin
            if (e.op == memReqPkg::OpStore) begin
                writeShadow(e.addr, e.wdata, int'(e.len));
            end else begin
                expData = readShadow(e.addr, int'(e.len));
            end
        end
        if (!doneF) begin
            expInst = readShadow(e.addr, 4);
        end
        stallLeft = e.stall ? 4 + int'($urandom % 6) : 0;
        @(posedge clk);
        fetchReqValid <= !doneF;
        fetchAddr     <= e.addr;
        dataReqValid  <= !doneD;
        dataOp        <= e.op;
        dataLen       <= e.len;
        dataAddr      <= e.addr;
        dataWdata     <= e.wdata;
        ioBufferFull  <= e.stall;
        while (!(doneF && doneD)) begin
            @(posedge clk);
            if (fetchReqValid && fetchReqReady) begin
                fetchReqValid <= 1'b0;
            end
            if (dataReqValid && dataReqReady) begin
                dataReqValid <= 1'b0;
            end
            if (ioBufferFull && (instValid || dataRespValid)) begin
                failRun("response appeared while the I/O buffer was full");
            end
            // payload is checked on every valid cycle, so it must hold steady
            if (instValid) begin
                checkInst(inst, expInst);
                if (fetchReqReady) begin
                    failRun("fetch request ready high while instruction is pending");
                end
                doneF = doneF || instReady;
            end
            if (dataRespValid) begin
                checkData(dataRdata, expData, e.op);
                if (dataReqReady) begin
                    failRun("data request ready high while data response is pending");
                end
                doneD = doneD || dataRespReady;
            end
            if (stallLeft > 0) begin
                stallLeft--;
            end
            ioBufferFull  <= (stallLeft > 0);
            instReady     <= !e.bp || ($urandom % 3 == 0);
            dataRespReady <= !e.bp || ($urandom % 3 == 0);
        end
        ioBufferFull  <= 1'b0;
        instReady     <= 1'b1;
        dataRespReady <= 1'b1;
    endtask

    initial begin
        wait (tableLoaded);
        repeat (40 * entries.size() + 8) @(posedge clk);
        $display("watchdog expired: a response never arrived within %0d entries", entries.size());
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(39176));
        rst           = 1'b1;
        ioBufferFull  = 1'b0;
        fetchReqValid = 1'b0;
        fetchAddr     = '0;
        instReady     = 1'b1;
        dataReqValid  = 1'b0;
        dataOp        = memReqPkg::OpLoad;
        dataLen       = memReqPkg::LenWord;
        dataAddr      = '0;
        dataWdata     = '0;
        dataRespReady = 1'b1;
        loadTable();
        tableLoaded = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        foreach (entries[i]) begin
            runEntry(entries[i]);
        end
        @(posedge clk);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/memReqPkg.sv
design/ramBusPkg.sv
design/byteBusIf.sv
design/fetchSequencer.sv
design/dataSequencer.sv
design/ramArbiter.sv
design/byteRam.sv
design/memSubsystem.sv
test/memSubsystemTb.sv
